/* verilog/mdu_arith_pkg.sv */
`default_nettype none

package mdu_arith_pkg;

  // **********************************************************
  // Data widths
  // **********************************************************

  // One machine word, for operands, results and registers
  typedef logic [31:0] word_t;

  // Adder width, a word plus sign and carry room
  typedef logic [33:0] sum_t;

  // **********************************************************
  // Operations and control word layout
  // **********************************************************

  typedef enum logic [1:0] {
    MULL = 2'd0,
    MULH = 2'd1,
    DIV  = 2'd2,
    REM  = 2'd3
  } mdu_op_e;

  // Operation sits in bits CTRL_OP_MSB down to 0
  localparam int unsigned CTRL_OP_MSB       = 1;
  localparam int unsigned CTRL_SIGNED_A_BIT = 2;
  localparam int unsigned CTRL_SIGNED_B_BIT = 3;

endpackage

`default_nettype wire

/* verilog/mdu_bus_pkg.sv */
`default_nettype none

package mdu_bus_pkg;

  typedef logic [1:0] resp_t;
  typedef logic [7:0] reg_offset_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Register map
  localparam reg_offset_t REG_A      = 8'h00;
  localparam reg_offset_t REG_B      = 8'h04;
  localparam reg_offset_t REG_CTRL   = 8'h08;
  localparam reg_offset_t REG_STATUS = 8'h0C;
  localparam reg_offset_t REG_RESULT = 8'h10;

endpackage

`default_nettype wire

/* verilog/mdu_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_adder (
  input  mdu_arith_pkg::sum_t  add_a,
  input  mdu_arith_pkg::sum_t  add_b,
  input  mdu_arith_pkg::word_t divisor,
  output mdu_arith_pkg::sum_t  sum,
  output mdu_arith_pkg::word_t sum_low,
  output logic                 not_zero
);

  // **********************************************************
  // Full width sum
  // **********************************************************

  // Multiply accumulate and trial subtract both use all 34 bits
  assign sum = add_a + add_b;

  // Low word tap, used with ~x + 1 to negate a word
  assign sum_low = sum[31:0];

  // **********************************************************
  // Divisor check
  // **********************************************************

  // Lets the core pick the divide by zero path in its first state
  assign not_zero = |divisor;

endmodule

`default_nettype wire

/* verilog/mdu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_core (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  mdu_arith_pkg::word_t   operand_a,
  input  mdu_arith_pkg::word_t   operand_b,
  input  mdu_arith_pkg::mdu_op_e op,
  input  logic                   signed_a,
  input  logic                   signed_b,
  output mdu_arith_pkg::sum_t    add_a,
  output mdu_arith_pkg::sum_t    add_b,
  input  mdu_arith_pkg::sum_t    sum,
  input  mdu_arith_pkg::word_t   sum_low,
  input  logic                   not_zero,
  output mdu_arith_pkg::word_t   result,
  output logic                   done
);

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    SIGN,
    FINISH
  } state_e;

  state_e               state_q;
  state_e               state_d;
  logic [4:0]           count_q;
  logic [4:0]           count_d;
  // Multiply: accumulator, multiplicand, multiplier
  // Divide: remainder window, quotient, divisor
  logic [32:0]          acc_q;
  logic [32:0]          acc_d;
  logic [32:0]          opa_q;
  logic [32:0]          opa_d;
  logic [32:0]          opb_q;
  logic [32:0]          opb_d;
  mdu_arith_pkg::word_t numer_q;
  mdu_arith_pkg::word_t numer_d;

  logic                 sign_a;
  logic                 sign_b;
  logic [32:0]          ext_a;
  logic [32:0]          ext_b;
  logic [32:0]          pp_first;
  logic [32:0]          pp_step;
  logic                 is_mul;
  logic                 trial_ge;
  mdu_arith_pkg::word_t rem_next;
  mdu_arith_pkg::word_t quot_next;
  logic                 change_sign;

  assign sign_a   = operand_a[31] & signed_a;
  assign sign_b   = operand_b[31] & signed_b;
  assign ext_a    = {sign_a, operand_a};
  assign ext_b    = {sign_b, operand_b};
  assign pp_first = ext_a & {33{operand_b[0]}};
  assign pp_step  = opa_q & {33{opb_q[0]}};
  assign is_mul   = (op == mdu_arith_pkg::MULL) || (op == mdu_arith_pkg::MULH);

  // Sign of window minus divisor, read from the top adder bit
  assign trial_ge    = ~sum[33];
  assign rem_next    = trial_ge ? sum[32:1] : acc_q[31:0];
  assign quot_next   = {opa_q[30:0], trial_ge};
  assign change_sign = (op == mdu_arith_pkg::DIV) ? (sign_a ^ sign_b) : sign_a;

  // MULH ends on the subtract of the multiplier sign term
  assign result = (op == mdu_arith_pkg::MULH) ? ~sum[31:0] : acc_q[31:0];
  assign done   = (state_q == FINISH) || (is_mul && (state_q == LAST));

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      count_q <= 5'd0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
    end
  end

  always_ff @(posedge clock) begin
    acc_q   <= acc_d;
    opa_q   <= opa_d;
    opb_q   <= opb_d;
    numer_q <= numer_d;
  end

  // **********************************************************
  // Next state
  // **********************************************************

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    acc_d   = acc_q;
    opa_d   = opa_q;
    opb_d   = opb_q;
    numer_d = numer_q;
    if (!start) begin
      state_d = IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          count_d = 5'd31;
          case (op)
            mdu_arith_pkg::MULL: begin
              acc_d   = {1'b0, operand_a & {32{operand_b[0]}}};
              opa_d   = {1'b0, operand_a[30:0], 1'b0};
              opb_d   = {2'b00, operand_b[31:1]};
              state_d = (operand_b[31:1] == 31'd0) ? LAST : COMP;
            end
            mdu_arith_pkg::MULH: begin
              // First partial product, already shifted right
              acc_d   = {pp_first[32], pp_first[32:1]};
              opa_d   = ext_a;
              opb_d   = {1'b0, ext_b[32:1]};
              state_d = COMP;
            end
            default: begin
              if (!not_zero) begin
                acc_d   = (op == mdu_arith_pkg::DIV) ? {1'b0, 32'hffff_ffff} :
                                                       {1'b0, operand_a};
                state_d = FINISH;
              end else begin
                state_d = ABS_A;
              end
            end
          endcase
        end

        ABS_A: begin
          numer_d = sign_a ? sum_low : operand_a;
          opa_d   = 33'd0;
          state_d = ABS_B;
        end

        ABS_B: begin
          opb_d   = {1'b0, sign_b ? sum_low : operand_b};
          acc_d   = {32'd0, numer_q[31]};
          state_d = COMP;
        end

        COMP: begin
          count_d = count_q - 5'd1;
          case (op)
            mdu_arith_pkg::MULL: begin
              acc_d   = {1'b0, sum[31:0]};
              opa_d   = {1'b0, opa_q[30:0], 1'b0};
              opb_d   = {1'b0, opb_q[32:1]};
              state_d = (opb_q[32:1] == 32'd0) ? LAST : COMP;
            end
            mdu_arith_pkg::MULH: begin
              acc_d   = sum[33:1];
              opb_d   = {1'b0, opb_q[32:1]};
              state_d = (count_q == 5'd1) ? LAST : COMP;
            end
            default: begin
              acc_d   = {rem_next, numer_q[count_d]};
              opa_d   = {1'b0, quot_next};
              state_d = (count_q == 5'd1) ? LAST : COMP;
            end
          endcase
        end

        LAST: begin
          if (is_mul) begin
            state_d = IDLE;
          end else begin
            acc_d   = (op == mdu_arith_pkg::DIV) ? {1'b0, quot_next} : {1'b0, rem_next};
            state_d = SIGN;
          end
        end

        SIGN: begin
          if (change_sign) begin
            acc_d = {1'b0, sum_low};
          end
          state_d = FINISH;
        end

        default: state_d = IDLE;
      endcase
    end
  end

  // **********************************************************
  // Adder operands
  // **********************************************************

  always_comb begin
    add_a = '0;
    add_b = '0;
    case (state_q)
      ABS_A: begin
        add_a = {2'b00, ~operand_a};
        add_b = 34'd1;
      end
      ABS_B: begin
        add_a = {2'b00, ~operand_b};
        add_b = 34'd1;
      end
      SIGN: begin
        add_a = {2'b00, ~acc_q[31:0]};
        add_b = 34'd1;
      end
      COMP, LAST: begin
        case (op)
          mdu_arith_pkg::MULL: begin
            add_a = {2'b00, acc_q[31:0]};
            add_b = {2'b00, pp_step[31:0]};
          end
          mdu_arith_pkg::MULH: begin
            // H - A is formed as ~(~H + A) on the sign step
            add_a = (state_q == LAST) ? ~{acc_q[32], acc_q} : {acc_q[32], acc_q};
            add_b = {pp_step[32], pp_step};
          end
          default: begin
            // Carry-in of one on both sides gives window minus divisor
            add_a = {acc_q, 1'b1};
            add_b = {~opb_q, 1'b1};
          end
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/mdu_axi_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_axi_regs #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [ADDR_WIDTH-1:0]  awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  mdu_arith_pkg::word_t   wdata,
  output logic                   bvalid,
  input  logic                   bready,
  output mdu_bus_pkg::resp_t     bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [ADDR_WIDTH-1:0]  araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output mdu_arith_pkg::word_t   rdata,
  output mdu_bus_pkg::resp_t     rresp,
  output mdu_arith_pkg::word_t   operand_a,
  output mdu_arith_pkg::word_t   operand_b,
  output mdu_arith_pkg::mdu_op_e op,
  output logic                   signed_a,
  output logic                   signed_b,
  output logic                   start,
  input  mdu_arith_pkg::word_t   result,
  input  logic                   done
);

  localparam logic [ADDR_WIDTH-1:0] OFS_A      = ADDR_WIDTH'(mdu_bus_pkg::REG_A);
  localparam logic [ADDR_WIDTH-1:0] OFS_B      = ADDR_WIDTH'(mdu_bus_pkg::REG_B);
  localparam logic [ADDR_WIDTH-1:0] OFS_CTRL   = ADDR_WIDTH'(mdu_bus_pkg::REG_CTRL);
  localparam logic [ADDR_WIDTH-1:0] OFS_STATUS = ADDR_WIDTH'(mdu_bus_pkg::REG_STATUS);
  localparam logic [ADDR_WIDTH-1:0] OFS_RESULT = ADDR_WIDTH'(mdu_bus_pkg::REG_RESULT);

  logic                 busy_q;
  logic                 done_flag_q;
  mdu_arith_pkg::word_t result_q;
  logic                 wr_accept;
  logic                 wr_error;
  logic                 rd_accept;
  logic                 rd_error;
  mdu_arith_pkg::word_t rd_data;

  // One response outstanding per side
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign rd_accept = arvalid && !rvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign arready   = rd_accept;
  assign start     = busy_q;

  // **********************************************************
  // Address decode
  // **********************************************************

  always_comb begin
    case (awaddr)
      OFS_A, OFS_B, OFS_CTRL: wr_error = busy_q;
      default:                wr_error = 1'b1;
    endcase
  end

  always_comb begin
    rd_data  = '0;
    rd_error = 1'b0;
    case (araddr)
      OFS_A:  rd_data = operand_a;
      OFS_B:  rd_data = operand_b;
      OFS_CTRL: begin
        rd_data[mdu_arith_pkg::CTRL_OP_MSB:0]     = op;
        rd_data[mdu_arith_pkg::CTRL_SIGNED_A_BIT] = signed_a;
        rd_data[mdu_arith_pkg::CTRL_SIGNED_B_BIT] = signed_b;
      end
      OFS_STATUS: rd_data = {30'd0, done_flag_q, busy_q};
      OFS_RESULT: rd_data = result_q;
      default:    rd_error = 1'b1;
    endcase
  end

  // **********************************************************
  // Handshake and operation tracking
  // **********************************************************

  always_ff @(posedge clock) begin
    if (reset) begin
      bvalid      <= 1'b0;
      rvalid      <= 1'b0;
      busy_q      <= 1'b0;
      done_flag_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_accept) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (wr_accept && !wr_error && (awaddr == OFS_CTRL)) begin
        busy_q      <= 1'b1;
        done_flag_q <= 1'b0;
      end else if (done) begin
        busy_q      <= 1'b0;
        done_flag_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_accept) begin
      bresp <= wr_error ? mdu_bus_pkg::RESP_SLVERR : mdu_bus_pkg::RESP_OKAY;
      if (!wr_error) begin
        case (awaddr)
          OFS_A: operand_a <= wdata;
          OFS_B: operand_b <= wdata;
          OFS_CTRL: begin
            op       <= mdu_arith_pkg::mdu_op_e'(wdata[mdu_arith_pkg::CTRL_OP_MSB:0]);
            signed_a <= wdata[mdu_arith_pkg::CTRL_SIGNED_A_BIT];
            signed_b <= wdata[mdu_arith_pkg::CTRL_SIGNED_B_BIT];
          end
          default: ;
        endcase
      end
    end
    if (rd_accept) begin
      rdata <= rd_data;
      rresp <= rd_error ? mdu_bus_pkg::RESP_SLVERR : mdu_bus_pkg::RESP_OKAY;
    end
    // Result stays here until read, the core never waits on the bus
    if (done) begin
      result_q <= result;
    end
  end

endmodule

`default_nettype wire

/* verilog/mdu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_top #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [ADDR_WIDTH-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  mdu_arith_pkg::word_t  wdata,
  output logic                  bvalid,
  input  logic                  bready,
  output mdu_bus_pkg::resp_t    bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [ADDR_WIDTH-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output mdu_arith_pkg::word_t  rdata,
  output mdu_bus_pkg::resp_t    rresp
);

  // Register block to core
  mdu_arith_pkg::word_t   operand_a;
  mdu_arith_pkg::word_t   operand_b;
  mdu_arith_pkg::mdu_op_e op;
  logic                   signed_a;
  logic                   signed_b;
  logic                   start;
  mdu_arith_pkg::word_t   result;
  logic                   done;

  // Core to adder
  mdu_arith_pkg::sum_t    add_a;
  mdu_arith_pkg::sum_t    add_b;
  mdu_arith_pkg::sum_t    sum;
  mdu_arith_pkg::word_t   sum_low;
  logic                   not_zero;

  mdu_axi_regs #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) mdu_axi_regs_i (
    .*
  );

  mdu_core mdu_core_i (
    .*
  );

  // Divisor check looks straight at the B operand register
  mdu_adder mdu_adder_i (
    .divisor(operand_b),
    .*
  );

endmodule

`default_nettype wire

/* testbench/mdu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_checker (
  input logic                 clock,
  input logic                 reset,
  input logic                 bvalid,
  input logic                 bready,
  input mdu_bus_pkg::resp_t   bresp,
  input logic                 rvalid,
  input logic                 rready,
  input mdu_arith_pkg::word_t rdata,
  input mdu_bus_pkg::resp_t   rresp
);

  int errors = 0;

  // Expected responses in the order the transactions were issued
  string                wr_name[$];
  mdu_bus_pkg::resp_t   wr_resp[$];
  string                rd_name[$];
  logic                 rd_check[$];
  mdu_arith_pkg::word_t rd_data[$];
  mdu_bus_pkg::resp_t   rd_resp[$];

  task automatic expect_write(input string name, input mdu_bus_pkg::resp_t resp);
    wr_name.push_back(name);
    wr_resp.push_back(resp);
  endtask

  task automatic expect_read(input string name, input logic check_data,
                             input mdu_arith_pkg::word_t data,
                             input mdu_bus_pkg::resp_t resp);
    rd_name.push_back(name);
    rd_check.push_back(check_data);
    rd_data.push_back(data);
    rd_resp.push_back(resp);
  endtask

  function automatic int outstanding();
    return wr_name.size() + rd_name.size();
  endfunction

  function automatic string resp_name(input mdu_bus_pkg::resp_t resp);
    case (resp)
      mdu_bus_pkg::RESP_OKAY:   return "OKAY";
      mdu_bus_pkg::RESP_SLVERR: return "SLVERR";
      default:                  return $sformatf("code %0d", resp);
    endcase
  endfunction

  // **********************************************************
  // Write response channel
  // **********************************************************

  always @(posedge clock) begin
    string              name;
    mdu_bus_pkg::resp_t want_resp;
    if (!reset && bvalid && bready) begin
      if (wr_name.size() == 0) begin
        $display("Write response arrived with no write outstanding");
        errors++;
      end else begin
        name      = wr_name.pop_front();
        want_resp = wr_resp.pop_front();
        if (bresp !== want_resp) begin
          $display("%s: write was answered with %s instead of %s",
                   name, resp_name(bresp), resp_name(want_resp));
          errors++;
        end
      end
    end
  end

  // **********************************************************
  // Read data channel
  // **********************************************************

  always @(posedge clock) begin
    string                name;
    logic                 want_check;
    mdu_arith_pkg::word_t want_data;
    mdu_bus_pkg::resp_t   want_resp;
    if (!reset && rvalid && rready) begin
      if (rd_name.size() == 0) begin
        $display("Read data arrived with no read outstanding");
        errors++;
      end else begin
        name       = rd_name.pop_front();
        want_check = rd_check.pop_front();
        want_data  = rd_data.pop_front();
        want_resp  = rd_resp.pop_front();
        if (rresp !== want_resp) begin
          $display("%s: read was answered with %s instead of %s",
                   name, resp_name(rresp), resp_name(want_resp));
          errors++;
        end
        if (want_check && (rdata !== want_data)) begin
          $display("MISMATCH %s: expected %08h, actual %08h", name, want_data, rdata);
          errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/mdu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_tb;

  localparam int ADDR_WIDTH = 8;
  localparam string STIM_FILE = "testbench/mdu_stim.txt";
  // Falls between RESULT and the end of the decoded space
  localparam logic [ADDR_WIDTH-1:0] UNMAPPED_OFS = 8'h14;

  logic                  clock;
  logic                  reset;
  logic                  awvalid;
  logic                  awready;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  mdu_arith_pkg::word_t  wdata;
  logic                  bvalid;
  logic                  bready;
  mdu_bus_pkg::resp_t    bresp;
  logic                  arvalid;
  logic                  arready;
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  rvalid;
  logic                  rready;
  mdu_arith_pkg::word_t  rdata;
  mdu_bus_pkg::resp_t    rresp;

  int seed = 32'h95a6;
  int errors = 0;
  int timeout_cycles = 0;

  // One entry per test line of the stimulus file
  string                test_name[$];
  int                   test_flags[$];
  mdu_arith_pkg::word_t test_a[$];
  mdu_arith_pkg::word_t test_b[$];
  mdu_arith_pkg::word_t test_ctrl[$];
  mdu_arith_pkg::word_t test_expected[$];

  mdu_top #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) mdu_top_i (
    .*
  );

  mdu_checker checker_i (
    .*
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Back-pressure of zero to three cycles
  function automatic int stall_cycles();
    return $unsigned($random(seed)) % 4;
  endfunction

  // **********************************************************
  // AXI4-Lite master
  // **********************************************************

  task automatic write_reg(input string name, input logic [ADDR_WIDTH-1:0] addr,
                           input mdu_arith_pkg::word_t data,
                           input mdu_bus_pkg::resp_t resp);
    int stall;
    stall = stall_cycles();
    checker_i.expect_write(name, resp);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    do @(posedge clock); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (stall) @(posedge clock);
    bready <= 1'b1;
    do @(posedge clock); while (!bvalid);
    bready <= 1'b0;
  endtask

  task automatic read_reg(input string name, input logic [ADDR_WIDTH-1:0] addr,
                          input logic check_data, input mdu_arith_pkg::word_t data,
                          input mdu_bus_pkg::resp_t resp,
                          output mdu_arith_pkg::word_t value);
    int stall;
    stall = stall_cycles();
    checker_i.expect_read(name, check_data, data, resp);
    arvalid <= 1'b1;
    araddr  <= addr;
    do @(posedge clock); while (!arready);
    arvalid <= 1'b0;
    repeat (stall) @(posedge clock);
    rready <= 1'b1;
    do @(posedge clock); while (!rvalid);
    rready <= 1'b0;
    value = rdata;
  endtask

  // Polls STATUS until the sticky done bit shows
  task automatic wait_done(input string name);
    mdu_arith_pkg::word_t status;
    status = '0;
    while (!status[1]) begin
      read_reg(name, mdu_bus_pkg::REG_STATUS, 1'b0, '0, mdu_bus_pkg::RESP_OKAY, status);
    end
  endtask

  // **********************************************************
  // Stimulus
  // **********************************************************

  task automatic load_stimulus();
    int                   fd;
    int                   fields;
    string                line;
    string                name;
    int                   flags;
    mdu_arith_pkg::word_t a;
    mdu_arith_pkg::word_t b;
    mdu_arith_pkg::word_t ctrl;
    mdu_arith_pkg::word_t expected;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ((line.len() > 0) && (line.getc(0) != "#")) begin
          fields = $sscanf(line, "%s %h %h %h %h %h", name, flags, a, b, ctrl, expected);
          if (fields == 6) begin
            test_name.push_back(name);
            test_flags.push_back(flags);
            test_a.push_back(a);
            test_b.push_back(b);
            test_ctrl.push_back(ctrl);
            test_expected.push_back(expected);
          end else if (fields > 0) begin
            $display("Stimulus line could not be parsed: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int i);
    mdu_arith_pkg::word_t value;
    write_reg(test_name[i], mdu_bus_pkg::REG_A, test_a[i], mdu_bus_pkg::RESP_OKAY);
    write_reg(test_name[i], mdu_bus_pkg::REG_B, test_b[i], mdu_bus_pkg::RESP_OKAY);
    write_reg(test_name[i], mdu_bus_pkg::REG_CTRL, test_ctrl[i], mdu_bus_pkg::RESP_OKAY);
    // Writes that arrive while the core runs bounce and change nothing
    if ((test_flags[i] & 1) != 0) begin
      read_reg(test_name[i], mdu_bus_pkg::REG_STATUS, 1'b1, 32'h1,
               mdu_bus_pkg::RESP_OKAY, value);
      write_reg(test_name[i], mdu_bus_pkg::REG_A, ~test_a[i], mdu_bus_pkg::RESP_SLVERR);
      write_reg(test_name[i], mdu_bus_pkg::REG_CTRL, test_ctrl[i] ^ 32'h3,
                mdu_bus_pkg::RESP_SLVERR);
    end
    wait_done(test_name[i]);
    // Busy has dropped once done shows
    read_reg(test_name[i], mdu_bus_pkg::REG_STATUS, 1'b1, 32'h2,
             mdu_bus_pkg::RESP_OKAY, value);
    read_reg(test_name[i], mdu_bus_pkg::REG_RESULT, 1'b1, test_expected[i],
             mdu_bus_pkg::RESP_OKAY, value);
    if ((test_flags[i] & 2) != 0) begin
      write_reg(test_name[i], mdu_bus_pkg::REG_RESULT, ~test_expected[i],
                mdu_bus_pkg::RESP_SLVERR);
      read_reg(test_name[i], mdu_bus_pkg::REG_RESULT, 1'b1, test_expected[i],
               mdu_bus_pkg::RESP_OKAY, value);
      read_reg(test_name[i], UNMAPPED_OFS, 1'b1, 32'h0, mdu_bus_pkg::RESP_SLVERR, value);
    end
  endtask

  // **********************************************************
  // Main sequence and watchdog
  // **********************************************************

  initial begin
    reset   = 1'b1;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    load_stimulus();
    timeout_cycles = test_name.size() * 200 + 100;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    if (test_name.size() == 0) begin
      $display("No tests found in %s", STIM_FILE);
      errors++;
    end
    for (int i = 0; i < test_name.size(); i++) begin
      run_test(i);
    end
    repeat (4) @(posedge clock);
    if (checker_i.outstanding() != 0) begin
      $display("%0d bus responses never arrived", checker_i.outstanding());
      errors++;
    end
    $display("Errors: testbench %0d, checker %0d", errors, checker_i.errors);
    if ((errors == 0) && (checker_i.errors == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge clock);
    $display("Timeout after %0d cycles, the DUT stopped answering", timeout_cycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/mdu_stim.txt */
# name flags a b ctrl expected, all but name in hex
# flags bit 0 probes busy writes, bit 1 probes bus errors; ctrl bits 1:0 op, 2 signed a, 3 signed b
mull_small      0 00000007 00000006 0 0000002a
mull_neg_ss     0 fffffffd 00000005 c fffffff1
mull_zero       2 12345678 00000000 0 00000000
mull_ones       0 ffffffff ffffffff 0 00000001
mull_mixed      0 12345678 9abcdef0 0 242d2080
mulh_mixed_uu   0 12345678 9abcdef0 1 0b00ea4e
mulh_ones_uu    1 ffffffff ffffffff 1 fffffffe
mulh_ones_ss    0 ffffffff ffffffff d 00000000
mulh_ones_su    0 ffffffff ffffffff 5 ffffffff
mulh_ones_us    0 ffffffff ffffffff 9 ffffffff
mulh_min_ss     0 80000000 80000000 d 40000000
mulh_neg_ss     0 fffffffd 00000005 d ffffffff
mulh_zero_ss    0 00000000 ffffffff d 00000000
div_uu          1 00000064 00000007 2 0000000e
rem_uu          0 00000064 00000007 3 00000002
div_neg_a       0 ffffff9c 00000007 e fffffff2
rem_neg_a       1 ffffff9c 00000007 f fffffffe
div_neg_b       0 00000064 fffffff9 e fffffff2
rem_neg_b       0 00000064 fffffff9 f 00000002
div_big_uu      0 ffffffff 00000010 2 0fffffff
rem_big_uu      2 ffffffff 00000010 3 0000000f
div_zero        0 12345678 00000000 2 ffffffff
div_zero_ss     0 87654321 00000000 e ffffffff
rem_zero        0 12345678 00000000 3 12345678
rem_zero_ss     0 87654321 00000000 f 87654321
div_overflow    0 80000000 ffffffff e 80000000
rem_overflow    0 80000000 ffffffff f 00000000

/* verilog.f */
verilog/mdu_arith_pkg.sv
verilog/mdu_bus_pkg.sv
verilog/mdu_adder.sv
verilog/mdu_core.sv
verilog/mdu_axi_regs.sv
verilog/mdu_top.sv
testbench/mdu_checker.sv
testbench/mdu_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := mdu_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
